//--- include/lq_defines.svh
// widths assume a 40-bit physical address and a 16-byte cache line, so change both together
`ifndef LQ_DEFINES_SVH
`define LQ_DEFINES_SVH

// physical address bits seen by the load/store unit
`define LQ_PA_WIDTH 40

// offset bits inside one 16-byte line
// the byte mask width is derived from this
`define LQ_LINE_OFS 4

`endif

//--- logic/lq_pkg.sv
// widths come from the defines header and the iid is fixed at 6 index bits plus one wrap bit
`include "lq_defines.svh"

package lq_pkg;

  // ================================================
  // widths
  // ================================================
  localparam int PA_WIDTH    = `LQ_PA_WIDTH;
  localparam int LINE_OFS    = `LQ_LINE_OFS;
  // line address, everything above the offset
  localparam int LINE_ADDR_W = PA_WIDTH - LINE_OFS;
  // one valid bit per byte of the line
  localparam int MASK_W      = 1 << LINE_OFS;
  // iid index bits, wrap bit sits on top
  localparam int IID_IDX_W   = 6;
  localparam int IID_W       = IID_IDX_W + 1;
  // retire ports from the reorder buffer
  localparam int CMIT_PORTS  = 3;

  // ================================================
  // basic types
  // ================================================
  typedef logic [PA_WIDTH-1:0]    pa_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [MASK_W-1:0]      byte_mask_t;
  typedef logic [IID_W-1:0]       iid_t;

  // ================================================
  // pipeline requests
  // ================================================
  // load dc stage, checks and creates
  typedef struct packed {
    logic       chk_vld;
    logic       chk1_vld;
    pa_t        addr0;
    pa_t        addr1;
    byte_mask_t mask0;
    byte_mask_t mask1;
    iid_t       iid;
    logic       secd;
  } ld_chk_t;

  // store dc stage, checks only
  typedef struct packed {
    logic       st_vld;
    logic       statomic_vld;
    pa_t        addr;
    byte_mask_t mask;
    iid_t       iid;
  } st_chk_t;

  // retire ports, one strobe and one iid each
  typedef struct packed {
    logic [CMIT_PORTS-1:0] vld;
    iid_t [CMIT_PORTS-1:0] iid;
  } cmit_t;

endpackage

//--- logic/lq_iid_compare.sv
// ids that are more than half the iid space apart are ordered wrongly by the wrap rule
`timescale 1ns/1ns

module lq_iid_compare (
  input  lq_pkg::iid_t iid0,
  input  lq_pkg::iid_t iid1,
  output logic         iid0_older
);

  import lq_pkg::*;

  logic wrap_same;
  logic idx0_lower;
  logic idx0_higher;

  // wrap bit is the msb
  assign wrap_same   = (iid0[IID_IDX_W] == iid1[IID_IDX_W]);

  // plain index compares
  assign idx0_lower  = (iid0[IID_IDX_W-1:0] < iid1[IID_IDX_W-1:0]);
  assign idx0_higher = (iid0[IID_IDX_W-1:0] > iid1[IID_IDX_W-1:0]);

  // within one lap the lower index issued first
  // across a wrap the higher index is still from the older lap
  assign iid0_older = wrap_same ? idx0_lower : idx0_higher;

endmodule

//--- logic/lq_entry.sv
// payload regs carry no reset and mean something only while vld is high
`timescale 1ns/1ns

module lq_entry (
  input  logic            lq_clk,
  input  logic            cpurst_b,
  input  logic            create0,
  input  logic            create1,
  input  lq_pkg::ld_chk_t ld_chk,
  input  lq_pkg::st_chk_t st_chk,
  input  lq_pkg::cmit_t   cmit,
  input  logic            flush,
  input  logic            corr_dis,
  output logic            vld,
  output logic            inst_hit,
  output logic            rar_fail,
  output logic            raw_fail
);

  import lq_pkg::*;

  // stored payload
  line_addr_t            entry_addr;
  byte_mask_t            entry_mask;
  iid_t                  entry_iid;
  logic                  entry_secd;

  // retire
  logic [CMIT_PORTS-1:0] cmit_hit;
  logic                  pop_vld;

  // age vs the two check pipes
  logic                  ld_iid_older;
  logic                  st_iid_older;
  logic                  newer_than_ld;
  logic                  newer_than_st;

  // rar terms
  logic                  rar_addr0_hit;
  logic                  rar_addr1_hit;
  logic                  rar_mask0_hit;
  logic                  rar_mask1_hit;
  logic                  rar_hit0;
  logic                  rar_hit1;

  // raw terms
  logic                  raw_addr_hit;
  logic                  raw_mask_hit;
  logic                  st_chk_vld;

  // ================================================
  // valid bit
  // ================================================
  // flush and retire win over create
  always_ff @(posedge lq_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld <= 1'b0;
    else if (flush || pop_vld)
      vld <= 1'b0;
    else if (create0 || create1)
      vld <= 1'b1;
  end

  // ================================================
  // payload
  // ================================================
  // create0 takes line 0 of the request
  // create1 takes the crossed line, always a second half
  always_ff @(posedge lq_clk)
  begin
    if (create0)
    begin
      entry_addr <= ld_chk.addr0[PA_WIDTH-1:LINE_OFS];
      entry_mask <= ld_chk.mask0;
      entry_iid  <= ld_chk.iid;
      entry_secd <= ld_chk.secd;
    end
    else if (create1)
    begin
      entry_addr <= ld_chk.addr1[PA_WIDTH-1:LINE_OFS];
      entry_mask <= ld_chk.mask1;
      entry_iid  <= ld_chk.iid;
      entry_secd <= 1'b1;
    end
  end

  // ================================================
  // retire
  // ================================================
  always_comb
  begin
    for (int p = 0; p < CMIT_PORTS; p++)
    begin
      cmit_hit[p] = cmit.vld[p] && (cmit.iid[p] == entry_iid);
    end
  end

  // any port naming this iid frees the slot
  assign pop_vld = vld && (|cmit_hit);

  // ================================================
  // duplicate detect
  // ================================================
  // same load half already queued, allocator skips it
  assign inst_hit = vld && (entry_secd == ld_chk.secd) && (entry_iid == ld_chk.iid);

  // ================================================
  // rar check
  // ================================================
  // checker older than entry means entry ran ahead
  lq_iid_compare x_cmp_ld_iid (
    .iid0       (ld_chk.iid  ),
    .iid1       (entry_iid   ),
    .iid0_older (ld_iid_older)
  );

  assign newer_than_ld = vld && ld_iid_older;

  // line compare above the offset
  assign rar_addr0_hit = (entry_addr == ld_chk.addr0[PA_WIDTH-1:LINE_OFS]);
  assign rar_addr1_hit = (entry_addr == ld_chk.addr1[PA_WIDTH-1:LINE_OFS]);
  // byte overlap
  assign rar_mask0_hit = |(entry_mask & ld_chk.mask0);
  assign rar_mask1_hit = |(entry_mask & ld_chk.mask1);

  assign rar_hit0 = newer_than_ld && ld_chk.chk_vld && rar_addr0_hit && rar_mask0_hit;
  assign rar_hit1 = newer_than_ld && ld_chk.chk1_vld && rar_addr1_hit && rar_mask1_hit;

  // corr_dis masks rar only
  assign rar_fail = (rar_hit0 || rar_hit1) && !corr_dis;

  // ================================================
  // raw check
  // ================================================
  lq_iid_compare x_cmp_st_iid (
    .iid0       (st_chk.iid  ),
    .iid1       (entry_iid   ),
    .iid0_older (st_iid_older)
  );

  assign newer_than_st = vld && st_iid_older;

  // atomic stores check the same way as plain stores
  assign st_chk_vld   = st_chk.st_vld || st_chk.statomic_vld;
  assign raw_addr_hit = (entry_addr == st_chk.addr[PA_WIDTH-1:LINE_OFS]);
  assign raw_mask_hit = |(entry_mask & st_chk.mask);

  assign raw_fail = newer_than_st && st_chk_vld && raw_addr_hit && raw_mask_hit;

endmodule

//--- logic/lq_alloc_ctrl.sv
// a load that finds too few free slots is dropped, so the producer has to watch lq_full
`timescale 1ns/1ns

module lq_alloc_ctrl #(
  parameter int LQ_ENTRIES = 12
) (
  input  lq_pkg::ld_chk_t       ld_chk,
  input  logic                  flush,
  input  logic [LQ_ENTRIES-1:0] entry_vld,
  input  logic [LQ_ENTRIES-1:0] entry_inst_hit,
  output logic [LQ_ENTRIES-1:0] create0,
  output logic [LQ_ENTRIES-1:0] create1,
  output logic                  lq_full
);

  // wide enough to count every slot free
  localparam int CNT_W = $clog2(LQ_ENTRIES + 1);

  logic [LQ_ENTRIES-1:0] free_vec;
  logic [LQ_ENTRIES-1:0] sel0;
  logic [LQ_ENTRIES-1:0] sel1;
  logic                  found0;
  logic                  found1;
  logic [CNT_W-1:0]      free_cnt;
  logic                  dup_hit;
  logic                  need_two;
  logic                  create_req;
  logic                  slots_ok;
  logic                  create_ok;

  assign free_vec = ~entry_vld;

  // ================================================
  // slot search
  // ================================================
  // lowest free slot for create0, next one up for create1
  always_comb
  begin
    sel0   = '0;
    sel1   = '0;
    found0 = 1'b0;
    found1 = 1'b0;
    for (int i = 0; i < LQ_ENTRIES; i++)
    begin
      if (free_vec[i])
      begin
        if (!found0)
        begin
          sel0[i] = 1'b1;
          found0  = 1'b1;
        end
        else if (!found1)
        begin
          sel1[i] = 1'b1;
          found1  = 1'b1;
        end
      end
    end
  end

  // free slot count
  always_comb
  begin
    free_cnt = '0;
    for (int i = 0; i < LQ_ENTRIES; i++)
    begin
      free_cnt = free_cnt + {{(CNT_W-1){1'b0}}, free_vec[i]};
    end
  end

  // room for a split load is no longer guaranteed
  assign lq_full = (free_cnt < CNT_W'(2));

  // ================================================
  // create strobes
  // ================================================
  // already queued, nothing to add
  assign dup_hit    = |entry_inst_hit;
  // line-crossing load wants two slots
  assign need_two   = ld_chk.chk1_vld;
  // flush blocks create
  assign create_req = ld_chk.chk_vld && !dup_hit && !flush;
  assign slots_ok   = need_two ? (free_cnt >= CNT_W'(2)) : (free_cnt >= CNT_W'(1));
  assign create_ok  = create_req && slots_ok;

  // one-hot per entry
  assign create0 = create_ok ? sel0 : '0;
  assign create1 = (create_ok && need_two) ? sel1 : '0;

endmodule

//--- logic/lq_hazard_report.sv
// violation pulses trail the check cycle by one clock and lq_empty follows the valid bits directly
`timescale 1ns/1ns

module lq_hazard_report #(
  parameter int LQ_ENTRIES = 12
) (
  input  logic                  lq_clk,
  input  logic                  cpurst_b,
  input  logic [LQ_ENTRIES-1:0] entry_vld,
  input  logic [LQ_ENTRIES-1:0] entry_rar_fail,
  input  logic [LQ_ENTRIES-1:0] entry_raw_fail,
  output logic                  rar_fail,
  output logic                  raw_fail,
  output logic                  lq_empty
);

  logic rar_any;
  logic raw_any;

  // ================================================
  // reduce per-entry results
  // ================================================
  // any entry hit this cycle
  assign rar_any = |entry_rar_fail;
  assign raw_any = |entry_raw_fail;

  // ================================================
  // registered pulses
  // ================================================
  // one flop stage, back-to-back checks give back-to-back pulses
  always_ff @(posedge lq_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rar_fail <= 1'b0;
      raw_fail <= 1'b0;
    end
    else
    begin
      rar_fail <= rar_any;
      raw_fail <= raw_any;
    end
  end

  // ================================================
  // occupancy
  // ================================================
  // no valid entry left
  assign lq_empty = ~|entry_vld;

endmodule

//--- logic/lq_top.sv
// reports rar and raw violations only and never replays or flushes by itself
`timescale 1ns/1ns

module lq_top #(
  parameter int LQ_ENTRIES = 12
) (
  input  logic            lq_clk,
  input  logic            cpurst_b,
  input  lq_pkg::ld_chk_t ld_chk,
  input  lq_pkg::st_chk_t st_chk,
  input  lq_pkg::cmit_t   cmit,
  input  logic            flush,
  input  logic            corr_dis,
  output logic            rar_fail,
  output logic            raw_fail,
  output logic            lq_full,
  output logic            lq_empty
);

  // per-entry status
  logic [LQ_ENTRIES-1:0] entry_vld;
  logic [LQ_ENTRIES-1:0] entry_inst_hit;
  logic [LQ_ENTRIES-1:0] entry_rar_fail;
  logic [LQ_ENTRIES-1:0] entry_raw_fail;

  // per-entry create strobes
  logic [LQ_ENTRIES-1:0] create0;
  logic [LQ_ENTRIES-1:0] create1;

  // ================================================
  // allocator
  // ================================================
  lq_alloc_ctrl #(
    .LQ_ENTRIES (LQ_ENTRIES)
  ) x_alloc_ctrl (
    .ld_chk         (ld_chk        ),
    .flush          (flush         ),
    .entry_vld      (entry_vld     ),
    .entry_inst_hit (entry_inst_hit),
    .create0        (create0       ),
    .create1        (create1       ),
    .lq_full        (lq_full       )
  );

  // ================================================
  // entry array
  // ================================================
  // every entry sees the same broadcast checks
  for (genvar i = 0; i < LQ_ENTRIES; i++)
  begin : g_entry
    lq_entry x_entry (
      .lq_clk   (lq_clk           ),
      .cpurst_b (cpurst_b         ),
      .create0  (create0[i]       ),
      .create1  (create1[i]       ),
      .ld_chk   (ld_chk           ),
      .st_chk   (st_chk           ),
      .cmit     (cmit             ),
      .flush    (flush            ),
      .corr_dis (corr_dis         ),
      .vld      (entry_vld[i]     ),
      .inst_hit (entry_inst_hit[i]),
      .rar_fail (entry_rar_fail[i]),
      .raw_fail (entry_raw_fail[i])
    );
  end

  // ================================================
  // reporter
  // ================================================
  lq_hazard_report #(
    .LQ_ENTRIES (LQ_ENTRIES)
  ) x_hazard_report (
    .lq_clk         (lq_clk        ),
    .cpurst_b       (cpurst_b      ),
    .entry_vld      (entry_vld     ),
    .entry_rar_fail (entry_rar_fail),
    .entry_raw_fail (entry_raw_fail),
    .rar_fail       (rar_fail      ),
    .raw_fail       (raw_fail      ),
    .lq_empty       (lq_empty      )
  );

endmodule

//--- tb/lq_tb.sv
// directed tests assume a 12-entry queue and drive inputs 1 ns after the rising edge
`timescale 1ns/1ns

module lq_tb;

  import lq_pkg::*;

  localparam int CLK_PERIOD    = 8;
  // cycle budget of each test in run order
  localparam int BUDGET_CYCLES = 12 + 40 + 20 + 40 + 40 + 20;
  localparam int WATCHDOG_NS   = (BUDGET_CYCLES + 50) * CLK_PERIOD;

  typedef struct packed {
    logic rar;
    logic raw;
  } fail_pair_t;

  logic       lq_clk;
  logic       cpurst_b;
  ld_chk_t    ld_chk;
  st_chk_t    st_chk;
  cmit_t      cmit;
  logic       flush;
  logic       corr_dis;
  logic       rar_fail;
  logic       raw_fail;
  logic       lq_full;
  logic       lq_empty;
  int         err_cnt;
  line_addr_t line_a;
  byte_mask_t mask_a;
  byte_mask_t mask_b;

  lq_top #(
    .LQ_ENTRIES (12)
  ) uut (
    .lq_clk   (lq_clk  ),
    .cpurst_b (cpurst_b),
    .ld_chk   (ld_chk  ),
    .st_chk   (st_chk  ),
    .cmit     (cmit    ),
    .flush    (flush   ),
    .corr_dis (corr_dis),
    .rar_fail (rar_fail),
    .raw_fail (raw_fail),
    .lq_full  (lq_full ),
    .lq_empty (lq_empty)
  );

  always #(CLK_PERIOD/2) lq_clk = ~lq_clk;

  // ================================================
  // compare tasks
  // ================================================
  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_fail_pair(input string name, input fail_pair_t exp,
                                 input fail_pair_t act);
    if (exp !== act)
    begin
      $display("FAIL %s: expected rar/raw %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  // ================================================
  // stimulus helpers
  // ================================================
  // lands 1 ns past the edge where outputs have settled
  task automatic next_cycle();
    @(posedge lq_clk);
    #1;
  endtask

  function automatic pa_t line_pa(input line_addr_t line);
    line_pa = {line, {LINE_OFS{1'b0}}};
  endfunction

  // single-line load request
  function automatic ld_chk_t load_req(input iid_t iid, input line_addr_t line,
                                       input byte_mask_t mask);
    ld_chk_t r;
    r         = '0;
    r.chk_vld = 1'b1;
    r.addr0   = line_pa(line);
    r.mask0   = mask;
    r.iid     = iid;
    return r;
  endfunction

  function automatic st_chk_t store_req(input iid_t iid, input line_addr_t line,
                                        input byte_mask_t mask, input logic atomic);
    st_chk_t r;
    r              = '0;
    r.st_vld       = !atomic;
    r.statomic_vld = atomic;
    r.addr         = line_pa(line);
    r.mask         = mask;
    r.iid          = iid;
    return r;
  endfunction

  function automatic fail_pair_t sampled_fails();
    fail_pair_t s;
    s.rar = rar_fail;
    s.raw = raw_fail;
    return s;
  endfunction

  task automatic send_load(input ld_chk_t req);
    ld_chk = req;
    next_cycle();
    ld_chk = '0;
  endtask

  task automatic commit_iid(input int port, input iid_t iid);
    cmit.vld[port] = 1'b1;
    cmit.iid[port] = iid;
    next_cycle();
    cmit = '0;
  endtask

  // all entries gone one edge later
  task automatic flush_queue(input string name);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    check_flag({name, " empty after flush"}, 1'b1, lq_empty);
  endtask

  // pulse one cycle after the check and gone the cycle after
  task automatic probe_load(input string name, input ld_chk_t req, input logic cdis,
                            input fail_pair_t exp);
    ld_chk   = req;
    corr_dis = cdis;
    next_cycle();
    ld_chk   = '0;
    corr_dis = 1'b0;
    check_fail_pair(name, exp, sampled_fails());
    next_cycle();
    check_fail_pair({name, " pulse end"}, 2'b00, sampled_fails());
  endtask

  task automatic probe_store(input string name, input st_chk_t req, input fail_pair_t exp);
    st_chk = req;
    next_cycle();
    st_chk = '0;
    check_fail_pair(name, exp, sampled_fails());
    next_cycle();
    check_fail_pair({name, " pulse end"}, 2'b00, sampled_fails());
  endtask

  // ================================================
  // directed tests
  // ================================================
  task automatic occupancy_and_commit();
    check_flag("reset empty", 1'b1, lq_empty);
    check_flag("reset full", 1'b0, lq_full);
    send_load(load_req(7'd5, line_a, mask_a));
    check_flag("one load empty", 1'b0, lq_empty);
    // unrelated iid leaves the entry
    commit_iid(0, 7'd9);
    check_flag("other commit empty", 1'b0, lq_empty);
    commit_iid(2, 7'd5);
    check_flag("port2 commit empty", 1'b1, lq_empty);
  endtask

  task automatic rar_ordering();
    // younger load 20 queued before older 10 checks
    flush_queue("rar hit");
    send_load(load_req(7'd20, line_a, mask_a));
    probe_load("rar hit", load_req(7'd10, line_a, mask_a), 1'b0, 2'b10);
    flush_queue("rar disjoint");
    send_load(load_req(7'd20, line_a, mask_a));
    probe_load("rar disjoint", load_req(7'd10, line_a, ~mask_a), 1'b0, 2'b00);
    flush_queue("rar other line");
    send_load(load_req(7'd20, line_a, mask_a));
    probe_load("rar other line", load_req(7'd10, line_a ^ 1, mask_a), 1'b0, 2'b00);
    flush_queue("rar younger");
    send_load(load_req(7'd20, line_a, mask_a));
    probe_load("rar younger", load_req(7'd30, line_a, mask_a), 1'b0, 2'b00);
    // corr_dis hides the same hit
    flush_queue("rar corr_dis");
    send_load(load_req(7'd20, line_a, mask_a));
    probe_load("rar corr_dis", load_req(7'd10, line_a, mask_a), 1'b1, 2'b00);
  endtask

  task automatic raw_ordering();
    flush_queue("raw");
    send_load(load_req(7'd40, line_a, mask_a));
    probe_store("raw older store", store_req(7'd35, line_a, mask_a, 1'b0), 2'b01);
    probe_store("raw younger store", store_req(7'd45, line_a, mask_a, 1'b0), 2'b00);
    probe_store("raw atomic", store_req(7'd36, line_a, mask_a, 1'b1), 2'b01);
  endtask

  task automatic split_and_duplicate();
    ld_chk_t split;
    ld_chk_t half;
    split          = load_req(7'd50, line_a, mask_a);
    split.chk1_vld = 1'b1;
    split.addr1    = line_pa(line_a + 1);
    split.mask1    = mask_b;
    // crossed line only hits the create1 entry
    flush_queue("split");
    send_load(split);
    probe_load("split addr1", load_req(7'd45, line_a + 1, mask_b), 1'b0, 2'b10);
    // two slots plus repeats of both halves
    flush_queue("dup");
    send_load(split);
    send_load(split);
    half      = load_req(7'd50, line_a + 1, mask_b);
    half.secd = 1'b1;
    send_load(half);
    // 2 used plus 8 more leaves 2 free and one more leaves 1
    for (int i = 0; i < 8; i++)
    begin
      send_load(load_req(iid_t'(51 + i), line_a, mask_a));
    end
    check_flag("dup fill 8 full", 1'b0, lq_full);
    send_load(load_req(7'd59, line_a, mask_a));
    check_flag("dup fill 9 full", 1'b1, lq_full);
  endtask

  task automatic full_and_flush();
    ld_chk_t split;
    flush_queue("full");
    for (int i = 1; i <= 10; i++)
    begin
      send_load(load_req(iid_t'(i), line_a, mask_a));
    end
    check_flag("full at 10", 1'b0, lq_full);
    send_load(load_req(7'd11, line_a, mask_a));
    check_flag("full at 11", 1'b1, lq_full);
    // one slot left and a split load needs two
    split          = load_req(7'd40, line_a ^ 1, mask_a);
    split.chk1_vld = 1'b1;
    split.addr1    = line_pa((line_a ^ 1) + 1);
    split.mask1    = mask_a;
    send_load(split);
    probe_load("full dropped", load_req(7'd30, line_a ^ 1, mask_a), 1'b0, 2'b00);
    flush_queue("full");
    check_flag("full after flush", 1'b0, lq_full);
  endtask

  task automatic wrap_age();
    // wrap 1 idx 2 is newer than wrap 0 idx 60
    flush_queue("wrap");
    send_load(load_req({1'b1, 6'd2}, line_a, mask_a));
    probe_load("wrap newer", load_req({1'b0, 6'd60}, line_a, mask_a), 1'b0, 2'b10);
    flush_queue("wrap reverse");
    send_load(load_req({1'b0, 6'd60}, line_a, mask_a));
    probe_load("wrap reverse", load_req({1'b1, 6'd2}, line_a, mask_a), 1'b0, 2'b00);
  endtask

  // ================================================
  // main sequence
  // ================================================
  initial
  begin
    lq_clk   = 1'b0;
    cpurst_b = 1'b0;
    ld_chk   = '0;
    st_chk   = '0;
    cmit     = '0;
    flush    = 1'b0;
    corr_dis = 1'b0;
    err_cnt  = 0;
    void'($urandom(32'h97dd_76b5));
    line_a = line_addr_t'({$urandom(), $urandom()});
    // bit 0 set and bit 15 clear keep both mask and inverse nonzero
    mask_a = (byte_mask_t'($urandom()) & 16'h7ffe) | 16'h0001;
    mask_b = byte_mask_t'($urandom()) | 16'h8000;
    repeat (2) @(posedge lq_clk);
    #1;
    cpurst_b = 1'b1;
    occupancy_and_commit();
    rar_ordering();
    raw_ordering();
    split_and_duplicate();
    full_and_flush();
    wrap_age();
    $display("tests done, %0d errors", err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // hang guard
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
logic/lq_pkg.sv
logic/lq_iid_compare.sv
logic/lq_entry.sv
logic/lq_alloc_ctrl.sv
logic/lq_hazard_report.sv
logic/lq_top.sv
tb/lq_tb.sv

//--- Bender.yml
package:
  name: lq_load_queue

sources:
  - include_dirs:
      - include
    files:
      - logic/lq_pkg.sv
      - logic/lq_iid_compare.sv
      - logic/lq_entry.sv
      - logic/lq_alloc_ctrl.sv
      - logic/lq_hazard_report.sv
      - logic/lq_top.sv
  - target: test
    files:
      - tb/lq_tb.sv
